// ==== hdl/mips_pkg.sv ====
// shared types for the core; the PC is a word index into a 256-entry instruction memory
package mips_pkg;

    localparam int WORD_W = 32;
    localparam int PC_W   = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [PC_W-1:0]   pc_t;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_e;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_RUN, SEQ_TRAP} seq_state_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_imm;     // b operand from the immediate
        logic    is_branch;
        logic    illegal;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic  we;
        pc_t   addr;
        word_t data;
    } imem_write_t;

    typedef struct packed {
        logic      valid;
        pc_t       pc;
        ctrl_t     ctrl;
        word_t     operand_a;
        word_t     operand_b;
        word_t     imm;         // sign extended
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        pc_t       pc;
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        pc_t       pc;
        ctrl_t     ctrl;
        word_t     result;
        reg_addr_t dest;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        pc_t       pc;
        reg_addr_t dest;
        word_t     data;
    } commit_t;

endpackage

// ==== hdl/fetch_unit.sv ====
// instruction memory is read asynchronously and should only be loaded while the core is idle
`timescale 1ns/1ps

module fetch_unit (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic                  run,
    input  logic                  stall,
    input  logic                  clear_pc,
    input  logic                  branch_taken,
    input  mips_pkg::pc_t         branch_target,
    input  mips_pkg::imem_write_t imem_load,
    output mips_pkg::pc_t         fetch_pc,
    output mips_pkg::word_t       fetch_word
);

    mips_pkg::word_t imem [2**mips_pkg::PC_W];

    always_ff @(posedge SYS_clk)
    begin
        if (imem_load.we)
            imem[imem_load.addr] <= imem_load.data;   // program load port
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            fetch_pc <= '0;
        else if (clear_pc)
            fetch_pc <= '0;                           // restart from index 0
        else if (run && !stall)
        begin
            if (branch_taken)
                fetch_pc <= branch_target;
            else
                fetch_pc <= fetch_pc + 1'b1;
        end
    end

    assign fetch_word = imem[fetch_pc];

endmodule

// ==== hdl/decode_unit.sv ====
// beq resolves here with no delay slot; only ALU results in memory are forwarded into decode
`timescale 1ns/1ps

module decode_unit (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                run,
    input  logic                flush,
    input  logic                stall,
    input  mips_pkg::pc_t       fetch_pc,
    input  mips_pkg::word_t     fetch_word,
    input  mips_pkg::commit_t   wb_write,
    input  logic [1:0]          fwd_sel,
    input  mips_pkg::word_t     mem_forward,
    output mips_pkg::reg_addr_t src_a,
    output mips_pkg::reg_addr_t src_b,
    output logic                use_a,
    output logic                use_b,
    output mips_pkg::id_ex_t    id_rec,
    output logic                branch_taken,
    output mips_pkg::pc_t       branch_target
);

    logic            if_valid;
    mips_pkg::pc_t   if_pc;
    mips_pkg::word_t if_word;
    logic [5:0]      opcode;
    logic [5:0]      funct;
    mips_pkg::word_t imm;
    mips_pkg::ctrl_t ctrl;
    mips_pkg::word_t regs [32];
    mips_pkg::word_t opnd_a;
    mips_pkg::word_t opnd_b;

    // register 0 reads as zero, a write in this cycle is seen immediately
    function automatic mips_pkg::word_t read_reg(input mips_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (wb_write.valid && wb_write.dest == addr)
            return wb_write.data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            if_valid <= 1'b0;
        else if (flush || !run || branch_taken)
            if_valid <= 1'b0;                  // bubble, kills the slot behind a beq
        else if (!stall)
            if_valid <= 1'b1;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
        begin
            if_pc   <= fetch_pc;
            if_word <= fetch_word;
        end
    end

    assign opcode = if_word[31:26];
    assign funct  = if_word[5:0];
    assign src_a  = if_word[25:21];
    assign src_b  = if_word[20:16];
    assign imm    = {{16{if_word[15]}}, if_word[15:0]};

    always_comb
    begin
        ctrl        = '0;
        ctrl.alu_op = mips_pkg::ALU_ADD;
        case (opcode)
            mips_pkg::OP_RTYPE:
            begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    mips_pkg::FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                    default:          ctrl.illegal = 1'b1;
                endcase
            end
            mips_pkg::OP_ADDI:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_imm   = 1'b1;
            end
            mips_pkg::OP_LW:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_imm   = 1'b1;
            end
            mips_pkg::OP_SW:
            begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_imm   = 1'b1;
            end
            mips_pkg::OP_BEQ: ctrl.is_branch = 1'b1;
            default:          ctrl.illegal   = 1'b1;
        endcase
        if (ctrl.illegal)
        begin
            ctrl.reg_write = 1'b0;             // carried to write-back with no side effects
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.is_branch = 1'b0;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (wb_write.valid)
            regs[wb_write.dest] <= wb_write.data;
    end

    assign use_a = if_valid && !ctrl.illegal;
    assign use_b = use_a && (opcode == mips_pkg::OP_RTYPE || opcode == mips_pkg::OP_SW ||
                             opcode == mips_pkg::OP_BEQ);

    assign opnd_a = fwd_sel[1] ? mem_forward : read_reg(src_a);
    assign opnd_b = fwd_sel[0] ? mem_forward : read_reg(src_b);

    assign branch_taken  = if_valid && ctrl.is_branch && !stall && (opnd_a == opnd_b);
    assign branch_target = if_pc + 1'b1 + imm[mips_pkg::PC_W-1:0];

    always_comb
    begin
        id_rec.valid     = if_valid;
        id_rec.pc        = if_pc;
        id_rec.ctrl      = ctrl;
        id_rec.operand_a = opnd_a;
        id_rec.operand_b = opnd_b;
        id_rec.imm       = imm;
        id_rec.dest      = (opcode == mips_pkg::OP_RTYPE) ? if_word[15:11] : src_b;
    end

endmodule

// ==== hdl/execute_unit.sv ====
// arithmetic wraps with no overflow detection; slt compares signed
`timescale 1ns/1ps

module execute_unit (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  logic              run,
    input  logic              flush,
    input  logic              stall,
    input  mips_pkg::id_ex_t  id_rec,
    output mips_pkg::id_ex_t  ex_rec,
    output mips_pkg::ex_mem_t ex_result
);

    mips_pkg::word_t alu_b;
    mips_pkg::word_t alu_out;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ex_rec <= '0;
        else if (flush || stall || !run)
            ex_rec <= '0;                      // bubble
        else
            ex_rec <= id_rec;
    end

    assign alu_b = ex_rec.ctrl.alu_imm ? ex_rec.imm : ex_rec.operand_b;

    always_comb
    begin
        case (ex_rec.ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_out = ex_rec.operand_a + alu_b;
            mips_pkg::ALU_SUB: alu_out = ex_rec.operand_a - alu_b;
            mips_pkg::ALU_AND: alu_out = ex_rec.operand_a & alu_b;
            mips_pkg::ALU_OR:  alu_out = ex_rec.operand_a | alu_b;
            mips_pkg::ALU_SLT:
                alu_out = {31'b0, $signed(ex_rec.operand_a) < $signed(alu_b)};
            default:           alu_out = '0;
        endcase
    end

    always_comb
    begin
        ex_result.valid      = ex_rec.valid;
        ex_result.pc         = ex_rec.pc;
        ex_result.ctrl       = ex_rec.ctrl;
        ex_result.alu_result = alu_out;
        ex_result.store_data = ex_rec.operand_b;   // rt value for sw
        ex_result.dest       = ex_rec.dest;
    end

endmodule

// ==== hdl/memory_writeback.sv ====
// DMEM_WORDS must be a power of two; the low two address bits are ignored
`timescale 1ns/1ps

module memory_writeback #(
    parameter int DMEM_WORDS = 64
) (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  logic              flush,
    input  mips_pkg::ex_mem_t ex_result,
    output mips_pkg::ex_mem_t mem_rec,
    output mips_pkg::word_t   mem_forward,
    output mips_pkg::mem_wb_t wb_rec,
    output mips_pkg::commit_t wb_write
);

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    mips_pkg::word_t    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] dmem_idx;
    mips_pkg::word_t    load_data;
    logic               store_en;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            mem_rec <= '0;
        else if (flush)
            mem_rec <= '0;
        else
            mem_rec <= ex_result;
    end

    assign dmem_idx  = mem_rec.alu_result[DMEM_AW+1:2];
    assign load_data = dmem[dmem_idx];

    // a store younger than a faulting instruction must not land
    assign store_en = mem_rec.valid && mem_rec.ctrl.mem_write &&
                      !(wb_rec.valid && wb_rec.ctrl.illegal);

    always_ff @(posedge SYS_clk)
    begin
        if (store_en)
            dmem[dmem_idx] <= mem_rec.store_data;
    end

    assign mem_forward = mem_rec.alu_result;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            wb_rec <= '0;
        else if (flush)
            wb_rec <= '0;
        else
        begin
            wb_rec.valid  <= mem_rec.valid;
            wb_rec.pc     <= mem_rec.pc;
            wb_rec.ctrl   <= mem_rec.ctrl;
            wb_rec.result <= mem_rec.ctrl.mem_read ? load_data : mem_rec.alu_result;
            wb_rec.dest   <= mem_rec.dest;
        end
    end

    assign wb_write.valid = wb_rec.valid && wb_rec.ctrl.reg_write && (wb_rec.dest != '0);
    assign wb_write.pc    = wb_rec.pc;
    assign wb_write.dest  = wb_rec.dest;
    assign wb_write.data  = wb_rec.result;

endmodule

// ==== hdl/hazard_unit.sv ====
// loads are never forwarded; a consumer waits until the load reaches write-back
`timescale 1ns/1ps

module hazard_unit (
    input  mips_pkg::reg_addr_t src_a,
    input  mips_pkg::reg_addr_t src_b,
    input  logic                use_a,
    input  logic                use_b,
    input  mips_pkg::id_ex_t    ex_rec,
    input  mips_pkg::ex_mem_t   mem_rec,
    output logic                stall,
    output logic [1:0]          fwd_sel
);

    logic ex_wr;
    logic mem_ld;
    logic mem_alu;
    logic need_a;
    logic need_b;

    assign ex_wr   = ex_rec.valid && ex_rec.ctrl.reg_write;
    assign mem_ld  = mem_rec.valid && mem_rec.ctrl.mem_read;
    assign mem_alu = mem_rec.valid && mem_rec.ctrl.reg_write && !mem_rec.ctrl.mem_read;

    assign need_a = use_a && (src_a != '0);    // r0 never creates a dependence
    assign need_b = use_b && (src_b != '0);

    assign stall = (need_a && ex_wr  && ex_rec.dest  == src_a) ||
                   (need_b && ex_wr  && ex_rec.dest  == src_b) ||
                   (need_a && mem_ld && mem_rec.dest == src_a) ||
                   (need_b && mem_ld && mem_rec.dest == src_b);

    assign fwd_sel[1] = need_a && mem_alu && mem_rec.dest == src_a;
    assign fwd_sel[0] = need_b && mem_alu && mem_rec.dest == src_b;

endmodule

// ==== hdl/core_sequencer.sv ====
// start is ignored while running; epc reads zero until a fault is taken
`timescale 1ns/1ps

module core_sequencer (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  logic              start,
    input  mips_pkg::mem_wb_t wb_rec,
    output logic              run,
    output logic              flush,
    output logic              clear_pc,
    output logic              trapped,
    output mips_pkg::pc_t     epc
);

    mips_pkg::seq_state_e state;
    logic                 go;
    logic                 fault;

    assign go    = start && (state != mips_pkg::SEQ_RUN);
    assign fault = (state == mips_pkg::SEQ_RUN) && wb_rec.valid && wb_rec.ctrl.illegal;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            state <= mips_pkg::SEQ_IDLE;
            epc   <= '0;
        end
        else if (go)
        begin
            state <= mips_pkg::SEQ_RUN;
            epc   <= '0;
        end
        else if (fault)
        begin
            state <= mips_pkg::SEQ_TRAP;
            epc   <= wb_rec.pc;                // index of the faulting instruction
        end
    end

    assign run      = (state == mips_pkg::SEQ_RUN);
    assign flush    = go || fault;             // empties every stage on either edge
    assign clear_pc = go;
    assign trapped  = (state == mips_pkg::SEQ_TRAP);

endmodule

// ==== hdl/mips_core.sv ====
// load the program only while idle; commit carries each nonzero register write in order
`timescale 1ns/1ps

module mips_core #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic                  start,
    input  mips_pkg::imem_write_t imem_load,
    output mips_pkg::commit_t     commit,
    output logic                  trapped,
    output mips_pkg::pc_t         epc
);

    logic                run;
    logic                flush;
    logic                clear_pc;
    logic                stall;
    logic [1:0]          fwd_sel;
    logic                branch_taken;
    mips_pkg::pc_t       branch_target;
    mips_pkg::pc_t       fetch_pc;
    mips_pkg::word_t     fetch_word;
    mips_pkg::word_t     mem_forward;
    mips_pkg::reg_addr_t src_a;
    mips_pkg::reg_addr_t src_b;
    logic                use_a;
    logic                use_b;
    mips_pkg::id_ex_t    id_rec;
    mips_pkg::id_ex_t    ex_rec;
    mips_pkg::ex_mem_t   ex_result;
    mips_pkg::ex_mem_t   mem_rec;
    mips_pkg::mem_wb_t   wb_rec;

    core_sequencer core_sequencer_i (.*);

    fetch_unit fetch_unit_i (.*);

    decode_unit decode_unit_i (
        .*,
        .wb_write (commit)                     // register write returned from write-back
    );

    hazard_unit hazard_unit_i (.*);

    execute_unit execute_unit_i (.*);

    memory_writeback #(
        .DMEM_WORDS (DMEM_WORDS)
    ) memory_writeback_i (
        .*,
        .wb_write (commit)
    );

endmodule

// ==== sim/tb_mips_core.sv ====
// programs run until an illegal opcode traps; model registers and memory persist across start
`timescale 1ns/1ps

module tb_mips_core;

    localparam int DMEM_WORDS   = 64;
    localparam int TRAP_TIMEOUT = 2000;
    localparam int PROG_LEN     = 40;

    localparam mips_pkg::word_t ILLEGAL_WORD = {6'h3f, 26'h0};

    logic                  SYS_clk;
    logic                  SYS_reset;
    logic                  start;
    mips_pkg::imem_write_t imem_load;
    mips_pkg::commit_t     commit;
    logic                  trapped;
    mips_pkg::pc_t         epc;

    integer                seed;
    int                    checks;
    int                    errors;
    bit                    hung;
    mips_pkg::word_t       prog [$];
    mips_pkg::commit_t     exp_q [$];
    mips_pkg::pc_t         exp_epc;
    mips_pkg::word_t       m_regs [32];
    mips_pkg::word_t       m_dmem [DMEM_WORDS];

    mips_core #(
        .DMEM_WORDS (DMEM_WORDS)
    ) mips_core_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .start     (start),
        .imem_load (imem_load),
        .commit    (commit),
        .trapped   (trapped),
        .epc       (epc)
    );

    always #4 SYS_clk = ~SYS_clk;

    function automatic mips_pkg::word_t r_word(input logic [5:0] fn, input int rd, input int rs,
                                               input int rt);
        return {mips_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t i_word(input logic [5:0] op, input int rt, input int rs,
                                               input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic int pick_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_commit(input mips_pkg::commit_t got);
        mips_pkg::commit_t want;
        checks++;
        if (exp_q.size() == 0)
        begin
            $display("unexpected commit at %0t: pc %0d wrote r%0d = %h", $time, got.pc,
                     got.dest, got.data);
            errors++;
        end
        else
        begin
            want = exp_q.pop_front();
            if (got !== want)
            begin
                $display("FAIL %0t commit: got pc %0d r%0d = %h, expected pc %0d r%0d = %h",
                         $time, got.pc, got.dest, got.data, want.pc, want.dest, want.data);
                errors++;
            end
        end
    endtask

    task automatic check_pc(input mips_pkg::pc_t got, input mips_pkg::pc_t want);
        checks++;
        if (got !== want)
        begin
            $display("FAIL %0t epc: got %0d, expected %0d", $time, got, want);
            errors++;
        end
    endtask

    // commit is registered, so mid-cycle sampling sees each record once
    always @(negedge SYS_clk)
    begin
        if (!SYS_reset && commit.valid)
            check_commit(commit);
    end

    task automatic model_write(input int pc, input mips_pkg::reg_addr_t dest,
                               input mips_pkg::word_t data);
        mips_pkg::commit_t c;
        if (dest != 0)                          // r0 writes vanish
        begin
            m_regs[dest] = data;
            c.valid = 1'b1;
            c.pc    = mips_pkg::pc_t'(pc);
            c.dest  = dest;
            c.data  = data;
            exp_q.push_back(c);
        end
    endtask

    // steps through prog at ISA level in program order
    task automatic run_model;
        int                  pc;
        int                  steps;
        int                  idx;
        bit                  done;
        logic [5:0]          op;
        logic [5:0]          fn;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t rd;
        mips_pkg::word_t     w;
        mips_pkg::word_t     a;
        mips_pkg::word_t     b;
        mips_pkg::word_t     imm;
        mips_pkg::word_t     addr;
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        exp_q.delete();
        while (!done && steps < 512)
        begin
            w     = prog[pc];
            op    = w[31:26];
            fn    = w[5:0];
            rs    = w[25:21];
            rt    = w[20:16];
            rd    = w[15:11];
            imm   = {{16{w[15]}}, w[15:0]};
            a     = m_regs[rs];
            b     = m_regs[rt];
            addr  = a + imm;
            idx   = (addr >> 2) % DMEM_WORDS;
            steps = steps + 1;
            case (op)
                mips_pkg::OP_RTYPE:
                begin
                    case (fn)
                        mips_pkg::FN_ADD: model_write(pc, rd, a + b);
                        mips_pkg::FN_SUB: model_write(pc, rd, a - b);
                        mips_pkg::FN_AND: model_write(pc, rd, a & b);
                        mips_pkg::FN_OR:  model_write(pc, rd, a | b);
                        mips_pkg::FN_SLT: model_write(pc, rd, ($signed(a) < $signed(b)) ? 1 : 0);
                        default:          done = 1'b1;
                    endcase
                end
                mips_pkg::OP_ADDI: model_write(pc, rt, addr);
                mips_pkg::OP_LW:   model_write(pc, rt, m_dmem[idx]);
                mips_pkg::OP_SW:   m_dmem[idx] = b;
                mips_pkg::OP_BEQ:
                begin
                    if (a == b)
                        pc = pc + int'($signed(imm));   // plus the usual one below
                end
                default:           done = 1'b1;
            endcase
            if (done)
                exp_epc = mips_pkg::pc_t'(pc);
            else
                pc = pc + 1;
        end
    endtask

    // trailing illegal words also catch a beq that jumps past the end
    task automatic end_program;
        repeat (4) prog.push_back(ILLEGAL_WORD);
    endtask

    task automatic gen_random_program;
        int kind;
        int rd;
        int rs;
        int rt;
        prog.delete();
        for (int i = 0; i < PROG_LEN; i++)
        begin
            kind = pick_below(9);
            rd   = pick_below(8);
            rs   = pick_below(8);
            rt   = pick_below(8);
            case (kind)
                0: prog.push_back(r_word(mips_pkg::FN_ADD, rd, rs, rt));
                1: prog.push_back(r_word(mips_pkg::FN_SUB, rd, rs, rt));
                2: prog.push_back(r_word(mips_pkg::FN_AND, rd, rs, rt));
                3: prog.push_back(r_word(mips_pkg::FN_OR, rd, rs, rt));
                4: prog.push_back(r_word(mips_pkg::FN_SLT, rd, rs, rt));
                5: prog.push_back(i_word(mips_pkg::OP_ADDI, rt, rs, pick_below(128) - 64));
                6: prog.push_back(i_word(mips_pkg::OP_LW, rt, 0, pick_below(DMEM_WORDS) * 4));
                7: prog.push_back(i_word(mips_pkg::OP_SW, rt, 0, pick_below(DMEM_WORDS) * 4));
                default: prog.push_back(i_word(mips_pkg::OP_BEQ, rt, rs, pick_below(4)));
            endcase
        end
        end_program();
    endtask

    task automatic load_program;
        for (int i = 0; i < prog.size(); i++)
        begin
            @(posedge SYS_clk);
            #1;
            imem_load.we   = 1'b1;
            imem_load.addr = mips_pkg::pc_t'(i);
            imem_load.data = prog[i];
        end
        @(posedge SYS_clk);
        #1;
        imem_load = '0;
    endtask

    task automatic run_program;
        int cycles;
        if (hung)
            return;                             // core is stuck, later programs cannot run
        load_program();
        run_model();
        @(posedge SYS_clk);
        #1;
        start = 1'b1;
        @(posedge SYS_clk);
        #1;
        start  = 1'b0;
        cycles = 0;
        while (!trapped && cycles < TRAP_TIMEOUT)
        begin
            @(posedge SYS_clk);
            #1;
            cycles = cycles + 1;
        end
        if (!trapped)
        begin
            $display("timeout: core never trapped within %0d cycles", TRAP_TIMEOUT);
            errors++;
            hung = 1'b1;
        end
        else
        begin
            repeat (2) @(posedge SYS_clk);   // nothing may retire after the trap
            #1;
            check_pc(epc, exp_epc);
            if (exp_q.size() != 0)
            begin
                $display("missing commits: %0d expected results never retired", exp_q.size());
                errors++;
                exp_q.delete();
            end
        end
    endtask

    initial
    begin
        SYS_clk   = 1'b0;
        SYS_reset = 1'b1;
        start     = 1'b0;
        imem_load = '0;
        seed      = 32'h079f_b5fd;
        checks    = 0;
        errors    = 0;
        hung      = 1'b0;
        exp_epc   = '0;
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            m_dmem[i] = '0;
        repeat (3) @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;

        // clear registers and data memory so the DUT matches the zeroed model
        prog.delete();
        for (int r = 1; r < 32; r++)
            prog.push_back(i_word(mips_pkg::OP_ADDI, r, 0, 0));
        for (int k = 0; k < DMEM_WORDS; k++)
            prog.push_back(i_word(mips_pkg::OP_SW, 0, 0, k * 4));
        end_program();
        run_program();

        prog.delete();                          // back-to-back dependencies
        prog.push_back(i_word(mips_pkg::OP_ADDI, 1, 0, 5));
        prog.push_back(i_word(mips_pkg::OP_ADDI, 2, 0, 7));
        prog.push_back(r_word(mips_pkg::FN_ADD, 3, 1, 2));
        prog.push_back(r_word(mips_pkg::FN_ADD, 4, 3, 3));
        prog.push_back(i_word(mips_pkg::OP_ADDI, 5, 0, 9));
        prog.push_back(i_word(mips_pkg::OP_SW, 5, 0, 12));
        prog.push_back(i_word(mips_pkg::OP_LW, 6, 0, 12));
        prog.push_back(r_word(mips_pkg::FN_ADD, 7, 6, 6));
        end_program();
        run_program();

        prog.delete();                          // beq taken then not taken
        prog.push_back(i_word(mips_pkg::OP_ADDI, 1, 0, 1));
        prog.push_back(i_word(mips_pkg::OP_BEQ, 1, 1, 2));
        prog.push_back(i_word(mips_pkg::OP_ADDI, 2, 0, 11));
        prog.push_back(i_word(mips_pkg::OP_ADDI, 3, 0, 12));
        prog.push_back(i_word(mips_pkg::OP_ADDI, 4, 0, 13));
        prog.push_back(i_word(mips_pkg::OP_BEQ, 0, 1, 1));
        prog.push_back(i_word(mips_pkg::OP_ADDI, 5, 0, 14));
        prog.push_back(i_word(mips_pkg::OP_ADDI, 6, 0, 15));
        end_program();
        run_program();

        prog.delete();                          // r0 as destination
        prog.push_back(i_word(mips_pkg::OP_ADDI, 0, 0, 33));
        prog.push_back(r_word(mips_pkg::FN_ADD, 0, 1, 1));
        prog.push_back(i_word(mips_pkg::OP_LW, 0, 0, 12));
        prog.push_back(r_word(mips_pkg::FN_OR, 6, 0, 0));
        end_program();
        run_program();

        prog.delete();                          // younger sw behind the fault must not land
        prog.push_back(i_word(mips_pkg::OP_ADDI, 1, 0, 77));
        prog.push_back(i_word(mips_pkg::OP_SW, 1, 0, 40));
        prog.push_back(i_word(mips_pkg::OP_ADDI, 2, 0, 99));
        prog.push_back(ILLEGAL_WORD);
        prog.push_back(i_word(mips_pkg::OP_SW, 2, 0, 40));
        end_program();
        run_program();

        prog.delete();
        prog.push_back(i_word(mips_pkg::OP_LW, 3, 0, 40));
        end_program();
        run_program();

        repeat (4)
        begin
            gen_random_program();
            run_program();
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== src.f ====
hdl/mips_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/memory_writeback.sv
hdl/hazard_unit.sv
hdl/core_sequencer.sv
hdl/mips_core.sv
sim/tb_mips_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; pass only if the log holds the pass line
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_mips_core -o tb_mips_core

./obj_dir/tb_mips_core | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
